/* sar_adc.f */
source/sar_adc_pkg.sv
source/adc_cmp_slice.sv
source/sar_ctrl.sv
source/adc_reg.sv
source/sar_adc.sv
testbench/tb_sar_adc.sv

/* source/adc_cmp_slice.sv */
`timescale 1ns/100ps

module adc_cmp_slice
    import sar_adc_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  sar_drive_t       drive,
    input  logic [DAC_W-1:0] din,
    output logic             cmp
);

    logic [DAC_W-1:0] held;   // Sample and hold
    logic [DAC_W-1:0] level;  // Level seen by the comparator

    // Hold tracks the input during the sample pulse
    assign level = drive.sample ? din : held;

    always_ff @(posedge clk)
    begin
        if (drive.sample)
            held <= din;
    end

    // Clocked comparator, one cycle from trial code to decision
    always_ff @(posedge clk)
    begin
        if (rst)
            cmp <= 1'b0;
        else
            cmp <= (level >= drive.code); // Keep bit when sample at or above code
    end

endmodule

/* source/adc_reg.sv */
`timescale 1ns/100ps

module adc_reg
    import sar_adc_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        reg_cs,
    input  logic        reg_wr,
    input  logic [7:0]  reg_addr,
    input  logic [31:0] reg_wdata,
    input  logic [3:0]  reg_be,
    input  adc_done_t   done,
    output logic [31:0] reg_rdata,
    output logic        reg_ack,
    output adc_cmd_t    cmd
);

    logic              access;     // First cycle of a bus access
    logic              ctrl_wr;
    logic              status_wr;
    logic [CHAN_W-1:0] chan;       // CTRL channel field
    logic              busy;
    logic              done_flag;  // Sticky done
    logic [DAC_W-1:0]  result;
    logic              start_q;
    logic [31:0]       rd_mux;

    assign access    = reg_cs && !reg_ack;
    // All fields live in byte lane 0
    assign ctrl_wr   = access && reg_wr && reg_be[0] && (reg_addr == REG_CTRL);
    assign status_wr = access && reg_wr && reg_be[0] && (reg_addr == REG_STATUS);

    // Single-cycle acknowledge
    always_ff @(posedge clk)
    begin
        if (rst)
            reg_ack <= 1'b0;
        else
            reg_ack <= access;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            chan      <= '0;
            busy      <= 1'b0;
            done_flag <= 1'b0;
            result    <= '0;
            start_q   <= 1'b0;
        end
        else
        begin
            start_q <= ctrl_wr && reg_wdata[0] && !busy; // Start dropped while busy

            if (ctrl_wr)
                chan <= reg_wdata[CHAN_W:1];

            if (done.valid)
            begin
                busy   <= 1'b0;
                result <= done.result;
            end
            else if (ctrl_wr && reg_wdata[0])
                busy <= 1'b1;

            // Set has priority over write-one-to-clear
            if (done.valid)
                done_flag <= 1'b1;
            else if (status_wr && reg_wdata[1])
                done_flag <= 1'b0;
        end
    end

    always_comb
    begin
        case (reg_addr)
            REG_CTRL:   rd_mux = {{(31-CHAN_W){1'b0}}, chan, 1'b0}; // Start reads 0
            REG_STATUS: rd_mux = {30'b0, done_flag, busy};
            REG_RESULT: rd_mux = {{(32-DAC_W){1'b0}}, result};
            default:    rd_mux = '0;
        endcase
    end

    // Read data valid in the acknowledge cycle
    always_ff @(posedge clk)
    begin
        if (access)
            reg_rdata <= rd_mux;
    end

    assign cmd.start = start_q;
    assign cmd.chan  = chan;

endmodule

/* source/sar_adc.sv */
`timescale 1ns/100ps

module sar_adc
    import sar_adc_pkg::*;
#(
    parameter int NUM_CHANNELS = 6
)
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                reg_cs,
    input  logic                                reg_wr,
    input  logic [7:0]                          reg_addr,
    input  logic [31:0]                         reg_wdata,
    input  logic [3:0]                          reg_be,
    output logic [31:0]                         reg_rdata,
    output logic                                reg_ack,
    input  logic                                pulse1m_mclk,
    output logic [DAC_W-1:0]                    sar2dac,     // Trial code toward DAC
    input  logic [NUM_CHANNELS-1:0][DAC_W-1:0]  analog_din   // Digital stand-in per channel
);

    adc_cmd_t                cmd;
    sar_drive_t              drive;
    adc_done_t               done;
    logic [NUM_CHANNELS-1:0] sar_cmp;  // Decision from each slice

    adc_reg u_adc_reg (
        .clk       (clk),
        .rst       (rst),
        .reg_cs    (reg_cs),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_be    (reg_be),
        .done      (done),
        .reg_rdata (reg_rdata),
        .reg_ack   (reg_ack),
        .cmd       (cmd)
    );

    sar_ctrl #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) u_sar_ctrl (
        .clk          (clk),
        .rst          (rst),
        .pulse1m_mclk (pulse1m_mclk),
        .cmd          (cmd),
        .cmp          (sar_cmp),
        .drive        (drive),
        .done         (done)
    );

    // One comparator per channel, all fed the same trial code
    for (genvar i = 0; i < NUM_CHANNELS; i++)
    begin : g_cmp
        adc_cmp_slice u_cmp (
            .clk   (clk),
            .rst   (rst),
            .drive (drive),
            .din   (analog_din[i]),
            .cmp   (sar_cmp[i])
        );
    end

    assign sar2dac = drive.code;

endmodule

/* source/sar_adc_pkg.sv */
package sar_adc_pkg;

    // Converter resolution, trial code and result
    localparam int DAC_W  = 8;

    // Channel number width, up to 8 channels
    localparam int CHAN_W = 3;

    // Register byte addresses
    localparam logic [7:0] REG_CTRL   = 8'h00; // Start and channel
    localparam logic [7:0] REG_STATUS = 8'h04; // Busy and sticky done
    localparam logic [7:0] REG_RESULT = 8'h08; // Last conversion result

    // Register block to SAR controller
    typedef struct packed {
        logic              start; // One-cycle start pulse
        logic [CHAN_W-1:0] chan;  // Channel to convert
    } adc_cmd_t;

    // SAR controller to every comparator slice
    typedef struct packed {
        logic             sample; // One-cycle sample pulse
        logic [DAC_W-1:0] code;   // Trial code toward the DAC
    } sar_drive_t;

    // SAR controller back to the register block
    typedef struct packed {
        logic             valid;  // One-cycle done pulse
        logic [DAC_W-1:0] result; // Final code
    } adc_done_t;

endpackage

/* source/sar_ctrl.sv */
`timescale 1ns/100ps

module sar_ctrl
    import sar_adc_pkg::*;
#(
    parameter int NUM_CHANNELS = 6
)
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pulse1m_mclk,
    input  adc_cmd_t                cmd,
    input  logic [NUM_CHANNELS-1:0] cmp,
    output sar_drive_t              drive,
    output adc_done_t               done
);

    localparam int IDX_W = $clog2(DAC_W);
    localparam int NSEL  = 2**CHAN_W;

    typedef enum logic [1:0] {
        IDLE,  // Waiting for a start
        ARMED, // Start seen, waiting for the first tick
        CONV   // Stepping through the bits
    } state_t;

    state_t            state;
    logic [CHAN_W-1:0] chan;       // Channel latched on start
    logic [DAC_W-1:0]  code;       // Trial code register
    logic [DAC_W-1:0]  code_next;
    logic [IDX_W-1:0]  bit_idx;    // Bit under trial
    logic              sample;
    logic [NSEL-1:0]   cmp_ext;    // Unused channels read as 0
    logic              dec;        // Decision of the latched channel

    assign cmp_ext = NSEL'(cmp);
    assign dec     = cmp_ext[chan];

    // Resolve current bit and set the next lower one
    always_comb
    begin
        code_next          = code;
        code_next[bit_idx] = dec;
        if (bit_idx != '0)
            code_next[bit_idx - 1'b1] = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= IDLE;
            chan       <= '0;
            code       <= '0;
            bit_idx    <= '0;
            sample     <= 1'b0;
            done.valid <= 1'b0;
        end
        else
        begin
            sample     <= 1'b0;
            done.valid <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (cmd.start)
                    begin
                        chan  <= cmd.chan;
                        state <= ARMED;
                    end
                end
                ARMED:
                begin
                    if (pulse1m_mclk)
                    begin
                        sample  <= 1'b1;
                        code    <= 8'h80;                // MSB trial first
                        bit_idx <= IDX_W'(DAC_W - 1);
                        state   <= CONV;
                    end
                end
                CONV:
                begin
                    if (pulse1m_mclk)
                    begin
                        code <= code_next;
                        if (bit_idx == '0)
                        begin
                            done.valid <= 1'b1;          // Last bit resolved
                            state      <= IDLE;
                        end
                        else
                            bit_idx <= bit_idx - 1'b1;
                    end
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // Result word, qualified by the done pulse
    always_ff @(posedge clk)
    begin
        if (state == CONV && pulse1m_mclk && bit_idx == '0)
            done.result <= code_next;
    end

    assign drive.sample = sample;
    assign drive.code   = code;

endmodule

/* testbench/tb_sar_adc.sv */
`timescale 1ns/100ps

module tb_sar_adc
    import sar_adc_pkg::*;
;

    localparam int NUM_CH    = 6;
    localparam int DRIVE_DLY = 10;   // Input change after the rising edge
    localparam int ACK_LIMIT = 20;   // Clocks to wait for reg_ack
    localparam int POLL_LIMIT = 200; // STATUS reads to wait for done

    logic                       clk;
    logic                       rst;
    logic                       reg_cs;
    logic                       reg_wr;
    logic [7:0]                 reg_addr;
    logic [31:0]                reg_wdata;
    logic [3:0]                 reg_be;
    logic [31:0]                reg_rdata;
    logic                       reg_ack;
    logic                       pulse1m_mclk;
    logic [DAC_W-1:0]           sar2dac;
    logic [NUM_CH-1:0][DAC_W-1:0] analog_din;

    integer      seed = 89;
    int          errors = 0;
    int          checks = 0;
    string       name_q[$];  // Pending checks for the compare process
    logic [31:0] got_q[$];
    logic [31:0] exp_q[$];

    sar_adc #(
        .NUM_CHANNELS (NUM_CH)
    ) u_sar_adc (
        .clk          (clk),
        .rst          (rst),
        .reg_cs       (reg_cs),
        .reg_wr       (reg_wr),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_be       (reg_be),
        .reg_rdata    (reg_rdata),
        .reg_ack      (reg_ack),
        .pulse1m_mclk (pulse1m_mclk),
        .sar2dac      (sar2dac),
        .analog_din   (analog_din)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // One-cycle tick every 4 clocks
    initial
    begin
        forever
        begin
            repeat (3) @(posedge clk);
            #DRIVE_DLY pulse1m_mclk = 1'b1;
            @(posedge clk);
            #DRIVE_DLY pulse1m_mclk = 1'b0;
        end
    end

    // Successive approximation with an ideal comparator
    function automatic logic [7:0] sar_ref(input logic [7:0] sample);
        logic [7:0] code;
        logic [7:0] trial;
        code = 8'h00;
        for (int b = 7; b >= 0; b--)
        begin
            trial = code | (8'h01 << b);
            if (sample >= trial)
                code = trial;
        end
        return code;
    endfunction

    task automatic finish_run();
        $display("Errors: %0d, checks: %0d", errors, checks);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    endtask

    task automatic queue_check(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    // Drain pending checks on the falling edge
    always @(negedge clk)
    begin
        string       name;
        logic [31:0] got;
        logic [31:0] exp;
        while (got_q.size() != 0)
        begin
            name = name_q.pop_front();
            got  = got_q.pop_front();
            exp  = exp_q.pop_front();
            checks++;
            if (got !== exp)
            begin
                $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
                errors++;
            end
        end
    end

    task automatic bus_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                              input logic [3:0] be, output logic [31:0] rdata);
        int count;
        count     = 0;
        rdata     = '0;
        reg_cs    = 1'b1;
        reg_wr    = wr;
        reg_addr  = addr;
        reg_wdata = data;
        reg_be    = be;
        @(posedge clk);
        #DRIVE_DLY;
        while (!reg_ack && count < ACK_LIMIT)
        begin
            @(posedge clk);
            #DRIVE_DLY;
            count++;
        end
        if (!reg_ack)
        begin
            $display("Timeout: no reg_ack for access to address 0x%02h", addr);
            errors++;
            finish_run();
        end
        else
        begin
            rdata  = reg_rdata;
            reg_cs = 1'b0;
            reg_wr = 1'b0;
        end
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] be);
        logic [31:0] unused;
        bus_access(1'b1, addr, data, be, unused);
    endtask

    task automatic expect_read(input string name, input logic [7:0] addr,
                               input logic [31:0] exp);
        logic [31:0] rdata;
        bus_access(1'b0, addr, 32'h0, 4'hF, rdata);
        queue_check(name, rdata, exp);
    endtask

    task automatic start_conv(input int chan);
        bus_write(REG_CTRL, (chan << 1) | 32'h1, 4'hF);
    endtask

    task automatic wait_done();
        logic [31:0] status;
        int          count;
        count = 0;
        bus_access(1'b0, REG_STATUS, 32'h0, 4'hF, status);
        while (!status[1] && count < POLL_LIMIT)
        begin
            bus_access(1'b0, REG_STATUS, 32'h0, 4'hF, status);
            count++;
        end
        if (!status[1])
        begin
            $display("Timeout: conversion never reported done");
            errors++;
            finish_run();
        end
    endtask

    task automatic randomize_inputs();
        for (int i = 0; i < NUM_CH; i++)
            analog_din[i] = 8'($random(seed));
    endtask

    initial
    begin
        int count;
        rst          = 1'b1;
        reg_cs       = 1'b0;
        reg_wr       = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        reg_be       = '0;
        pulse1m_mclk = 1'b0;
        analog_din   = '0;
        repeat (5) @(posedge clk);
        #DRIVE_DLY rst = 1'b0;

        // Reset values
        queue_check("reg_ack", 32'(reg_ack), 32'h0);
        queue_check("sar2dac", 32'(sar2dac), 32'h0);
        expect_read("STATUS", REG_STATUS, 32'h0);
        expect_read("RESULT", REG_RESULT, 32'h0);
        expect_read("CTRL", REG_CTRL, 32'h0);

        // Every channel with random samples
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
            randomize_inputs();
            start_conv(ch);
            expect_read("STATUS.busy", REG_STATUS, 32'h1);
            wait_done();
            expect_read("RESULT", REG_RESULT, 32'(sar_ref(analog_din[ch])));
            expect_read("CTRL", REG_CTRL, 32'(ch << 1));
            bus_write(REG_STATUS, 32'h0, 4'hF);
            expect_read("STATUS.done", REG_STATUS, 32'h2); // Still sticky
            bus_write(REG_STATUS, 32'h2, 4'hF);
            expect_read("STATUS", REG_STATUS, 32'h0);
        end

        // Start while busy is dropped
        randomize_inputs();
        analog_din[4] = ~analog_din[1];
        start_conv(1);
        start_conv(4);
        wait_done();
        expect_read("RESULT", REG_RESULT, 32'(sar_ref(analog_din[1])));
        bus_write(REG_STATUS, 32'h2, 4'hF);

        // No start with lane 0 disabled
        bus_write(REG_CTRL, 32'h5, 4'b1110);
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        expect_read("STATUS", REG_STATUS, 32'h0);

        // Edge codes on channel 2
        analog_din[2] = 8'h00;
        start_conv(2);
        wait_done();
        expect_read("RESULT", REG_RESULT, 32'h00);
        bus_write(REG_STATUS, 32'h2, 4'hF);
        analog_din[2] = 8'hFF;
        start_conv(2);
        wait_done();
        expect_read("RESULT", REG_RESULT, 32'hFF);
        bus_write(REG_STATUS, 32'h2, 4'hF);
        analog_din[2] = 8'h80;
        start_conv(2);
        wait_done();
        expect_read("RESULT", REG_RESULT, 32'h80);
        bus_write(REG_STATUS, 32'h2, 4'hF);

        // Let the compare process catch up
        count = 0;
        while (got_q.size() != 0 && count < 10)
        begin
            @(posedge clk);
            #DRIVE_DLY;
            count++;
        end
        if (got_q.size() != 0)
        begin
            $display("Compare process left checks unfinished");
            errors++;
        end
        finish_run();
    end

endmodule
